// File: compile.f
+incdir+logic
logic/fpSopPkg.sv
logic/fp16Multiplier.sv
logic/addDecode.sv
logic/addExecute.sv
logic/addResult.sv
logic/fpAddPipe.sv
logic/fpSopChain.sv
verification/fpSopChainTb.sv

// File: logic/addDecode.sv
`timescale 1ns/1ps
`include "fpSop_defines.svh"

module addDecode (
	input  fpSopPkg::fp32Word a,
	input  fpSopPkg::fp32Word b,
	output fpSopPkg::alignedOps ops
);
	import fpSopPkg::*;

	localparam int SHIFT_W = $clog2(`ALIGN_W);   // Shifts below ALIGN_W fit here

	fp32Word bigOp;
	fp32Word smallOp;
	logic bSwap;                                // B has the larger magnitude
	logic [`FP32_EXP_W-1:0] expDiff;
	logic [SHIFT_W-1:0] shiftAmt;
	logic shiftOut;                             // Whole significand shifted away
	logic [`ALIGN_W-1:0] manSmallRaw;
	logic [`ALIGN_W-1:0] coarse;
	logic [`ALIGN_W-1:0] fine;

	//////////////////////////////
	// Operand ordering
	//////////////////////////////

	// Exponent then fraction, so a plain compare orders magnitudes
	assign bSwap = {a.exponent, a.fraction} < {b.exponent, b.fraction};
	assign bigOp = bSwap ? b : a;
	assign smallOp = bSwap ? a : b;

	assign expDiff = bigOp.exponent - smallOp.exponent;   // Never negative
	assign shiftAmt = expDiff[SHIFT_W-1:0];
	assign shiftOut = expDiff >= `FP32_EXP_W'(`ALIGN_W);

	// Zero exponent field, whole significand is zero
	assign manSmallRaw = (smallOp.exponent == '0) ? '0 : {1'b1, smallOp.fraction};

	//////////////////////////////
	// Alignment shifter
	//////////////////////////////

	// Coarse step in multiples of four
	always_comb begin
		case (shiftAmt[SHIFT_W-1:2])
			3'd0: coarse = manSmallRaw;
			3'd1: coarse = manSmallRaw >> 4;
			3'd2: coarse = manSmallRaw >> 8;
			3'd3: coarse = manSmallRaw >> 12;
			3'd4: coarse = manSmallRaw >> 16;
			3'd5: coarse = manSmallRaw >> 20;
			default: coarse = '0;               // 24 and above, caught by shiftOut too
		endcase
	end

	assign fine = coarse >> shiftAmt[1:0];    // Remaining 0 to 3

	always_comb begin
		ops.signBig = bigOp.sign;
		ops.signSmall = smallOp.sign;
		ops.expBig = bigOp.exponent;
		ops.manBig = (bigOp.exponent == '0) ? '0 : {1'b1, bigOp.fraction};
		ops.manSmall = shiftOut ? '0 : fine;   // Saturate large gaps to zero
		ops.effSub = bigOp.sign ^ smallOp.sign;
	end

endmodule

// File: logic/addExecute.sv
`timescale 1ns/1ps
`include "fpSop_defines.svh"

module addExecute (
	input  fpSopPkg::alignedOps ops,
	output fpSopPkg::normSum norm
);

	localparam int LZ_W = $clog2(`SUM_W + 1);           // Counts 0 to SUM_W
	localparam int MAN_LSB = `SUM_W - 1 - `FP32_MAN_W;  // Fraction LSB after normalize
	localparam int EXP_W = `FP32_EXP_W + 1;             // Signed room

	logic [`SUM_W-1:0] bigExt;
	logic [`SUM_W-1:0] smallExt;
	logic [`SUM_W-1:0] sumRaw;
	logic [LZ_W-1:0] leadZeros;
	logic [`SUM_W-1:0] coarse;
	logic [`SUM_W-1:0] sumNorm;
	logic zeroSum;

	// Carry bit on top, guard space below
	assign bigExt = {1'b0, ops.manBig, {`GUARD_BITS{1'b0}}};
	assign smallExt = {1'b0, ops.manSmall, {`GUARD_BITS{1'b0}}};

	// Big minus small stays non-negative
	assign sumRaw = ops.effSub ? (bigExt - smallExt) : (bigExt + smallExt);
	assign zeroSum = (sumRaw == '0);

	//////////////////////////////
	// Leading one and normalize
	//////////////////////////////

	// Priority encoder, highest set bit wins
	always_comb begin
		leadZeros = LZ_W'(`SUM_W);             // All zero
		for (int i = 0; i < `SUM_W; i++) begin
			if (sumRaw[i]) begin
				leadZeros = LZ_W'(`SUM_W - 1 - i);
			end
		end
	end

	// Two level left shift, leading one ends in the top bit
	assign coarse = sumRaw << {leadZeros[LZ_W-1:2], 2'b00};
	assign sumNorm = coarse << leadZeros[1:0];

	always_comb begin
		norm.normMan = sumNorm[`SUM_W-2:MAN_LSB];
		// One leading zero means no change, carry gives plus one
		norm.normExp = $signed({1'b0, ops.expBig}) + EXP_W'(1)
			- $signed({{(EXP_W - LZ_W){1'b0}}, leadZeros});
		norm.zeroSum = zeroSum;
		norm.guardBit = sumNorm[MAN_LSB-1];
		norm.roundBit = sumNorm[MAN_LSB-2];
		norm.stickyBit = |sumNorm[MAN_LSB-3:0];
		// Exact cancellation is +0, two negative zeros stay negative
		norm.signOut = zeroSum ? (ops.signBig & ops.signSmall) : ops.signBig;
	end

endmodule

// File: logic/addResult.sv
`timescale 1ns/1ps
`include "fpSop_defines.svh"

module addResult (
	input  fpSopPkg::normSum norm,
	output fpSopPkg::fp32Word sum
);

	localparam int MAN_W = `FP32_MAN_W;
	localparam int EXP_W = `FP32_EXP_W;

	logic roundUp;
	logic [MAN_W:0] manRounded;               // Extra bit catches the carry
	logic manCarry;
	logic [EXP_W-1:0] expRounded;

	// Nearest even, a tie rounds up only onto an even LSB
	assign roundUp = norm.guardBit & (norm.roundBit | norm.stickyBit | norm.normMan[0]);

	assign manRounded = {1'b0, norm.normMan} + {{MAN_W{1'b0}}, roundUp};
	assign manCarry = manRounded[MAN_W];      // All ones rolled over

	// Carry leaves the fraction at zero, bump the exponent
	assign expRounded = norm.normExp[EXP_W-1:0] + {{(EXP_W - 1){1'b0}}, manCarry};

	always_comb begin
		sum.sign = norm.signOut;              // Zero sign already resolved
		if (norm.zeroSum) begin
			sum.exponent = '0;
			sum.fraction = '0;
		end else begin
			sum.exponent = expRounded;
			sum.fraction = manRounded[MAN_W-1:0];
		end
	end

endmodule

// File: logic/fp16Multiplier.sv
`timescale 1ns/1ps
`include "fpSop_defines.svh"

module fp16Multiplier (
	input  fpSopPkg::fp16Word a,
	input  fpSopPkg::fp16Word b,
	output fpSopPkg::fp32Word product
);

	localparam int SIG_W = `FP16_MAN_W + 1;             // Hidden bit plus fraction
	localparam int PROD_W = 2 * SIG_W;                  // 22 bit significand product
	localparam int PAD_W = `FP32_MAN_W - (PROD_W - 2);  // Low zeros when no carry out
	localparam int EXP_W = `FP32_EXP_W;
	// Rebias from two fp16 exponents to one fp32 exponent
	localparam logic [EXP_W-1:0] EXP_OFFSET = EXP_W'(`FP32_BIAS - 2 * `FP16_BIAS);

	logic [SIG_W-1:0] sigA;
	logic [SIG_W-1:0] sigB;
	logic [PROD_W-1:0] sigProd;
	logic carryOut;
	logic isZero;
	logic [EXP_W-1:0] expSum;

	assign sigA = {1'b1, a.fraction};
	assign sigB = {1'b1, b.fraction};
	assign sigProd = sigA * sigB;            // Exact, never needs rounding
	assign carryOut = sigProd[PROD_W-1];     // Product in [2,4)

	// Zero exponent field counts as zero
	assign isZero = (a.exponent == '0) || (b.exponent == '0);

	assign expSum = EXP_W'(a.exponent) + EXP_W'(b.exponent) + EXP_OFFSET
		+ EXP_W'(carryOut);

	always_comb begin
		product.sign = a.sign ^ b.sign;      // Kept even for zero
		if (isZero) begin
			product.exponent = '0;
			product.fraction = '0;
		end else if (carryOut) begin
			// Leading one at top, drop it and pad
			product.exponent = expSum;
			product.fraction = {sigProd[PROD_W-2:0], {(PAD_W - 1){1'b0}}};
		end else begin
			product.exponent = expSum;
			product.fraction = {sigProd[PROD_W-3:0], {PAD_W{1'b0}}};
		end
	end

endmodule

// File: logic/fpAddPipe.sv
`timescale 1ns/1ps

module fpAddPipe (
	input  logic clk,
	input  logic rst,
	input  fpSopPkg::fp32Word a,
	input  fpSopPkg::fp32Word b,
	output fpSopPkg::fp32Word sum
);
	import fpSopPkg::*;

	alignedOps decodeOut;
	alignedOps stage1;      // Aligned operands
	normSum executeOut;
	normSum stage2;         // Normalized sum
	normSum stage3;         // Feeds rounding

	//////////////////////////////
	// Stage logic
	//////////////////////////////

	addDecode decodeStage (
		.a   (a),
		.b   (b),
		.ops (decodeOut)
	);

	addExecute executeStage (
		.ops  (stage1),
		.norm (executeOut)
	);

	// Rounding is combinational after the last register
	addResult resultStage (
		.norm (stage3),
		.sum  (sum)
	);

	//////////////////////////////
	// Pipeline registers
	//////////////////////////////

	// Three registers, sum valid three edges after operands
	always_ff @(posedge clk) begin
		if (rst) begin
			stage1 <= '0;
			stage2 <= '0;
			stage3 <= '0;       // All-zero payload packs to +0
		end else begin
			stage1 <= decodeOut;
			stage2 <= executeOut;
			stage3 <= stage2;
		end
	end

endmodule

// File: logic/fpSopChain.sv
`timescale 1ns/1ps

module fpSopChain (
	input  logic clk,
	input  logic rst,
	input  fpSopPkg::fp16Word topA,
	input  fpSopPkg::fp16Word topB,
	input  fpSopPkg::fp16Word botA,
	input  fpSopPkg::fp16Word botB,
	input  fpSopPkg::fp32Word chainin,
	output fpSopPkg::fp32Word result,
	output fpSopPkg::fp32Word chainout
);
	import fpSopPkg::*;

	fp16Word topAReg;
	fp16Word topBReg;
	fp16Word botAReg;
	fp16Word botBReg;
	fp32Word prodTop;
	fp32Word prodBot;
	fp32Word partialSum;     // Sum of the two products
	fp32Word chainSum;

	// Operand input registers
	always_ff @(posedge clk) begin
		if (rst) begin
			topAReg <= '0;
			topBReg <= '0;
			botAReg <= '0;
			botBReg <= '0;
		end else begin
			topAReg <= topA;
			topBReg <= topB;
			botAReg <= botA;
			botBReg <= botB;
		end
	end

	//////////////////////////////
	// Products
	//////////////////////////////

	fp16Multiplier mulTop (.a(topAReg), .b(topBReg), .product(prodTop));
	fp16Multiplier mulBot (.a(botAReg), .b(botBReg), .product(prodBot));

	//////////////////////////////
	// Adder chain
	//////////////////////////////

	fpAddPipe sumPipe (
		.clk (clk),
		.rst (rst),
		.a   (prodTop),
		.b   (prodBot),
		.sum (partialSum)
	);

	// Chain input joins here unregistered, four edges behind the operands
	fpAddPipe chainPipe (
		.clk (clk),
		.rst (rst),
		.a   (partialSum),
		.b   (chainin),
		.sum (chainSum)
	);

	assign result = chainSum;
	assign chainout = chainSum;   // Feeds the next block in the column

endmodule

// File: logic/fpSopPkg.sv
`include "fpSop_defines.svh"

package fpSopPkg;

	// Half precision input word
	typedef struct packed {
		logic sign;
		logic [`FP16_EXP_W-1:0] exponent;
		logic [`FP16_MAN_W-1:0] fraction;
	} fp16Word;

	// Single precision word, products and sums
	typedef struct packed {
		logic sign;
		logic [`FP32_EXP_W-1:0] exponent;
		logic [`FP32_MAN_W-1:0] fraction;
	} fp32Word;

	//////////////////////////////
	// Adder stage payloads
	//////////////////////////////

	// Decode to execute
	typedef struct packed {
		logic signBig;                     // Sign of larger magnitude
		logic signSmall;
		logic [`FP32_EXP_W-1:0] expBig;    // Common exponent
		logic [`ALIGN_W-1:0] manBig;       // Hidden bit included
		logic [`ALIGN_W-1:0] manSmall;     // Already shifted right
		logic effSub;                      // Signs differ
	} alignedOps;

	// Execute to result
	typedef struct packed {
		logic [`FP32_MAN_W-1:0] normMan;   // Fraction below leading one
		logic signed [`FP32_EXP_W:0] normExp;
		logic zeroSum;
		logic guardBit;                    // First bit below LSB
		logic roundBit;
		logic stickyBit;                   // OR of everything lower
		logic signOut;
	} normSum;

endpackage

// File: logic/fpSop_defines.svh
`ifndef FPSOP_DEFINES_SVH
`define FPSOP_DEFINES_SVH

// Half precision operand fields
`define FP16_EXP_W 5
`define FP16_MAN_W 10
`define FP16_BIAS 15

// Single precision fields
`define FP32_EXP_W 8
`define FP32_MAN_W 23
`define FP32_BIAS 127

// Adder datapath
`define ALIGN_W 24    // Hidden bit plus fraction
`define GUARD_BITS 8  // Room below the LSB for normalize and round

// Carry bit, aligned significand, guard bits
`define SUM_W (1 + `ALIGN_W + `GUARD_BITS)

`endif

// File: verification/fpSopChainTb.sv
`timescale 1ns/1ps

module fpSopChainTb;
	import fpSopPkg::*;

	localparam int WORDS_PER_VEC = 6;     // Six hex words per file line
	localparam int MAX_VECS = 64;
	localparam int LATENCY = 7;           // Operand drive edge to result edge
	localparam int CHAIN_DELAY = 4;       // chainin trails its operands
	localparam int FIRST_TIMEOUT = 20;    // Cycles allowed for the first result
	localparam int FILLER_EVERY = 4;      // Directed vectors per group
	localparam int FILLER_LEN = 2;        // Zero-product items between groups

	// One stream item
	typedef struct packed {
		fp16Word topA;
		fp16Word topB;
		fp16Word botA;
		fp16Word botB;
		fp32Word chainin;
		fp32Word expected;
		logic isFiller;
	} testVec;

	logic clk = 1'b0;
	logic rst;
	fp16Word topA;
	fp16Word topB;
	fp16Word botA;
	fp16Word botB;
	fp32Word chainin;
	fp32Word result;
	fp32Word chainout;

	logic [31:0] stimMem [0:WORDS_PER_VEC*MAX_VECS-1];
	testVec items[$];          // Directed vectors with fillers mixed in
	integer seed;
	int checkCount;
	int mismatchCount;
	int failCount;             // Timeouts, latency and load problems

	fpSopChain u_fpSopChain (
		.clk      (clk),
		.rst      (rst),
		.topA     (topA),
		.topB     (topB),
		.botA     (botA),
		.botB     (botB),
		.chainin  (chainin),
		.result   (result),
		.chainout (chainout)
	);

	always #5 clk = ~clk;      // 10 ns period

	//////////////////////////////
	// Helpers
	//////////////////////////////

	task automatic checkValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		checkCount++;
		if (actual !== expected) begin
			mismatchCount++;
			$display("** Error: %s = 0x%08h, expected 0x%08h at %0t",
				name, actual, expected, $time);
		end
	endtask

	task automatic driveOperands(input testVec v);
		topA <= v.topA;         // Non-blocking, called right after a rising edge
		topB <= v.topB;
		botA <= v.botA;
		botB <= v.botB;
	endtask

	// Signed zeros only, so the sum is just the chain input
	task automatic buildFiller(output testVec v);
		logic [31:0] signs;
		logic [31:0] r;
		signs = $random(seed);
		r = $random(seed);
		v.topA = {signs[0], 15'h0000};
		v.topB = {signs[1], 15'h0000};
		v.botA = {signs[2], 15'h0000};
		v.botB = {signs[3], 15'h0000};
		v.chainin = {r[31], 8'd64 + {1'b0, r[29:23]}, r[22:0]};   // Normal, mid range
		v.expected = v.chainin;
		v.isFiller = 1'b1;
	endtask

	task automatic loadVectors();
		testVec v;
		testVec f;
		int n;
		int base;
		$readmemh("verification/fpSopStim.txt", stimMem);
		n = 0;
		// Unread words stay X and end the list
		while (n < MAX_VECS && !$isunknown(stimMem[n*WORDS_PER_VEC])) begin
			base = n * WORDS_PER_VEC;
			v.topA = stimMem[base][15:0];
			v.topB = stimMem[base+1][15:0];
			v.botA = stimMem[base+2][15:0];
			v.botB = stimMem[base+3][15:0];
			v.chainin = stimMem[base+4];
			v.expected = stimMem[base+5];
			v.isFiller = 1'b0;
			items.push_back(v);
			n++;
			if (n % FILLER_EVERY == 0) begin
				repeat (FILLER_LEN) begin
					buildFiller(f);
					items.push_back(f);
				end
			end
		end
	endtask

	// Cleared pipeline reads zero
	task automatic checkIdle();
		repeat (3) begin
			@(posedge clk);
			@(negedge clk);
			checkValue("result after reset", result, 32'h0);
			checkValue("chainout after reset", chainout, 32'h0);
		end
	endtask

	//////////////////////////////
	// Test phases
	//////////////////////////////

	// Lone vector, count edges until the sum shows up
	task automatic waitFirstResult(input testVec v);
		testVec idle;
		int cycles;
		logic seen;
		idle = '0;
		cycles = 0;
		seen = 1'b0;
		@(posedge clk);
		driveOperands(v);
		while (!seen && cycles < FIRST_TIMEOUT) begin
			@(posedge clk);
			cycles++;
			driveOperands(idle);
			chainin <= (cycles == CHAIN_DELAY) ? v.chainin : '0;
			@(negedge clk);
			if (result !== 32'h0) begin
				seen = 1'b1;
			end
		end
		if (!seen) begin
			failCount++;
			$display("Timeout: no result within %0d cycles of the first vector", FIRST_TIMEOUT);
		end else begin
			if (cycles != LATENCY) begin
				failCount++;
				$display("First result arrived after %0d cycles instead of %0d", cycles, LATENCY);
			end
			checkValue("result first vector", result, v.expected);
			checkValue("chainout first vector", chainout, v.expected);
		end
	endtask

	// One item per cycle, each checked exactly LATENCY cycles later
	task automatic runStream();
		testVec idle;
		int n;
		int idx;
		string tag;
		idle = '0;
		n = items.size();
		for (int c = 0; c < n + LATENCY; c++) begin
			@(posedge clk);
			driveOperands((c < n) ? items[c] : idle);
			if (c >= CHAIN_DELAY && c - CHAIN_DELAY < n) begin
				chainin <= items[c - CHAIN_DELAY].chainin;
			end else begin
				chainin <= '0;
			end
			@(negedge clk);     // Outputs settled
			if (c >= LATENCY) begin
				idx = c - LATENCY;
				tag = $sformatf("item %0d%s", idx, items[idx].isFiller ? " filler" : "");
				checkValue({"result ", tag}, result, items[idx].expected);
				checkValue({"chainout ", tag}, chainout, items[idx].expected);
			end
		end
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial begin
		seed = 32'h80299d6a;
		checkCount = 0;
		mismatchCount = 0;
		failCount = 0;
		rst = 1'b1;
		// Nonzero inputs for the whole reset
		topA = 16'h3C00;
		topB = 16'h3C00;
		botA = 16'h3C00;
		botB = 16'h3C00;
		chainin = 32'h3F800000;
		loadVectors();
		repeat (10) @(posedge clk);
		rst <= 1'b0;
		topA <= '0;             // Idle inputs from the release edge on
		topB <= '0;
		botA <= '0;
		botB <= '0;
		chainin <= '0;
		checkIdle();
		if (items.size() == 0) begin
			failCount++;
			$display("No vectors could be read from the stimulus file");
		end else begin
			waitFirstResult(items[0]);
			runStream();
		end
		$display("Checks %0d, mismatches %0d, other failures %0d",
			checkCount, mismatchCount, failCount);
		if (mismatchCount == 0 && failCount == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

// File: verification/fpSopStim.txt
// Columns: topA topB botA botB (fp16), chainin (fp32), expected result (fp32)
// Expected is RNE(RNE(topA*topB + botA*botB) + chainin)
3E00 3E00 0000 0000 00000000 40100000
BE00 4200 0000 0000 00000000 C0900000
3F00 3D00 0000 0000 00000000 400C0000
3C01 3C01 0000 0000 00000000 3F804008
3FFF 3FFF 0000 0000 00000000 407FC004
3C00 3C00 3C00 3C00 00000000 40000000
3E00 3C00 BE00 3C00 00000000 00000000
3C00 3C00 C000 3E00 00000000 C0000000
3D00 3C00 BC00 3C00 00000000 3E800000
BE00 3E00 BC00 3800 00000000 C0300000
3C00 3C00 0000 0000 40000000 40400000
3C00 3C00 0000 0000 4B800000 4B800000
3E00 3E00 0000 0000 CE800000 CE800000
3C00 3C00 0000 0000 4B000000 4B000001
4000 4000 BC00 3C00 3E800000 40500000
3C00 3C00 0000 0000 3F800001 40000000
3C00 3C00 0000 0000 3F800003 40000002
3C00 3C00 0000 0000 3F800002 40000001
3C00 3C00 0000 0000 3FFFFFFF 40400000
0400 1800 0000 0000 3FFFFFFF 40000000
BC00 3C00 0000 0000 BF800001 C0000000
0123 4000 3C00 3C00 00000000 3F800000
